//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing -j 0
TOP      := tb_team_01
FILELIST := tb.f
OBJDIR   := obj_dir
LOG      := sim.log

BIN  := $(OBJDIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- rtl/key_entry.sv
// ==============================
// Key entry and command decode
// Issues bus requests
// ==============================

module key_entry (
   input  logic             clk,
   input  logic             rst_n_i,
   input  ui_pkg::key_evt_t key_i,
   input  wb_pkg::wb_rsp_t  rsp_i,
   input  logic             lcd_busy_i,
   output wb_pkg::wb_req_t  req_o
);
   import ui_pkg::*;

   logic [31:0] acc_q;
   logic [31:0] addr_q;
   logic        pending_q;
   logic        accept;

   // Keys dropped during a transfer or while printing
   assign accept = key_i.valid && !pending_q && !lcd_busy_i;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         acc_q       <= '0;
         addr_q      <= '0;
         pending_q   <= 1'b0;
         req_o.valid <= 1'b0;
      end else begin
         req_o.valid <= 1'b0;
         // Transfer finished
         if (rsp_i.done) pending_q <= 1'b0;
         if (accept) begin
            if (!key_i.is_cmd) begin
               // Digit goes in as the low nibble
               acc_q <= {acc_q[27:0], key_i.code.digit};
            end else begin
               case (key_i.code.cmd)
                  CMD_ADDR: begin
                     addr_q <= acc_q;
                     acc_q  <= '0;
                  end
                  CMD_WRITE: begin
                     req_o.adr   <= addr_q;
                     req_o.dat   <= acc_q;
                     req_o.we    <= 1'b1;
                     req_o.valid <= 1'b1;
                     pending_q   <= 1'b1;
                  end
                  CMD_READ: begin
                     // Data field unused on a read
                     req_o.adr   <= addr_q;
                     req_o.dat   <= acc_q;
                     req_o.we    <= 1'b0;
                     req_o.valid <= 1'b1;
                     pending_q   <= 1'b1;
                  end
                  CMD_CLEAR: begin
                     acc_q  <= '0;
                     addr_q <= '0;
                  end
                  default: ;
               endcase
            end
         end
      end
   end

endmodule

//--- rtl/keypad_scan.sv
// ==============================
// 4x4 keypad column scanner
// Debounce and one event per press
// ==============================

module keypad_scan #(
   parameter int SCAN_DIV        = 8,
   parameter int DEBOUNCE_PASSES = 2
) (
   input  logic             clk,
   input  logic             rst_n_i,
   input  logic [3:0]       rows_i,
   output logic [3:0]       cols_o,
   output ui_pkg::key_evt_t key_o
);
   import ui_pkg::*;

   localparam int DW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
   localparam int PW = $clog2(DEBOUNCE_PASSES + 1);

   logic [DW-1:0] div_cnt;
   logic [1:0]    col_idx;
   logic [3:0]    rows_s1;
   logic [3:0]    rows_s2;
   logic          slot_end;
   logic          slot_hit;
   logic [1:0]    slot_row;
   logic [3:0]    slot_key;
   logic          scan_hit;
   logic [3:0]    scan_key;
   logic          merged_hit;
   logic [3:0]    merged_key;
   logic [3:0]    prev_key;
   logic          armed;
   logic [PW-1:0] pass_cnt;
   logic [PW-1:0] pass_next;
   key_evt_t      evt;

   // One column driven high at a time
   assign cols_o   = 4'b0001 << col_idx;
   assign slot_end = (div_cnt == DW'(SCAN_DIV - 1));
   assign slot_hit = |rows_s2;
   // Row-major index is row*4 + col
   assign slot_key = {slot_row, col_idx};

   always_comb begin
      // Lowest pressed row wins
      slot_row = 2'd0;
      for (int r = 3; r >= 0; r--) begin
         if (rows_s2[r]) slot_row = 2'(r);
      end
      // Keep the lowest key index seen so far in this scan
      merged_hit = scan_hit | slot_hit;
      if (slot_hit && (!scan_hit || slot_key < scan_key)) merged_key = slot_key;
      else merged_key = scan_key;
      // Same key as last scan extends the run
      if (pass_cnt != '0 && merged_key == prev_key) pass_next = pass_cnt + 1'b1;
      else pass_next = PW'(1);
   end

   // Key index to event lookup
   always_comb begin
      evt        = '0;
      evt.is_cmd = (merged_key >= 4'd10);
      case (merged_key)
         4'd10:   evt.code.cmd = CMD_ADDR;
         4'd11:   evt.code.cmd = CMD_WRITE;
         4'd12:   evt.code.cmd = CMD_READ;
         4'd13:   evt.code.cmd = CMD_CLEAR;
         default: evt.code.digit = merged_key;
      endcase
      // Fires on the last slot of the deciding scan, keys 14 and 15 dropped
      evt.valid = slot_end && (col_idx == 2'd3) && merged_hit && armed &&
                  (pass_next == PW'(DEBOUNCE_PASSES)) && (merged_key < 4'd14);
   end

   always_ff @(posedge clk) begin
      // Two stage synchronizer on the row inputs
      rows_s1 <= rows_i;
      rows_s2 <= rows_s1;
      if (!rst_n_i) begin
         div_cnt     <= '0;
         col_idx     <= 2'd0;
         scan_hit    <= 1'b0;
         armed       <= 1'b1;
         pass_cnt    <= '0;
         key_o.valid <= 1'b0;
      end else begin
         key_o   <= evt;
         div_cnt <= slot_end ? '0 : div_cnt + 1'b1;
         if (slot_end) begin
            col_idx <= col_idx + 2'd1;
            if (col_idx != 2'd3) begin
               scan_hit <= merged_hit;
               scan_key <= merged_key;
            end else begin
               // Full scan done
               scan_hit <= 1'b0;
               prev_key <= merged_key;
               if (!merged_hit) begin
                  // Release scan rearms
                  armed    <= 1'b1;
                  pass_cnt <= '0;
               end else if (armed) begin
                  pass_cnt <= pass_next;
                  if (pass_next == PW'(DEBOUNCE_PASSES)) armed <= 1'b0;
               end
            end
         end
      end
   end

endmodule

//--- rtl/lcd_writer.sv
// ==============================
// Character LCD writer
// Clear plus eight hex digits
// ==============================

module lcd_writer #(
   parameter int EN_CYCLES = 4
) (
   input  logic            clk,
   input  logic            rst_n_i,
   input  wb_pkg::wb_rsp_t rsp_i,
   output logic [7:0]      lcd_data_o,
   output logic            lcd_rs_o,
   output logic            lcd_en_o,
   output logic            busy_o
);
   import ui_pkg::*;

   localparam int         TW        = (EN_CYCLES > 1) ? $clog2(EN_CYCLES) : 1;
   localparam logic [3:0] LAST_BYTE = 4'd8;

   logic [TW-1:0] timer_q;
   logic [3:0]    byte_idx;
   logic [31:0]   shift_q;
   logic          phase_end;
   logic          start;

   assign phase_end = (timer_q == TW'(EN_CYCLES - 1));
   assign start     = !busy_o && rsp_i.done;

   // Byte 0 is the clear command, then text from the top nibble down
   always_comb begin
      if (byte_idx == 4'd0) begin
         lcd_data_o = LCD_CLEAR;
         lcd_rs_o   = 1'b0;
      end else begin
         lcd_data_o = HEX_ASCII[shift_q[31:28]];
         lcd_rs_o   = 1'b1;
      end
   end

   // Word latched on done, shifted after each hex character
   always_ff @(posedge clk) begin
      if (start) shift_q <= rsp_i.dat;
      else if (busy_o && phase_end && !lcd_en_o && byte_idx != 4'd0) begin
         shift_q <= {shift_q[27:0], 4'h0};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         busy_o   <= 1'b0;
         lcd_en_o <= 1'b0;
         byte_idx <= 4'd0;
         timer_q  <= '0;
      end else if (!busy_o) begin
         if (rsp_i.done) begin
            busy_o   <= 1'b1;
            lcd_en_o <= 1'b1;
            byte_idx <= 4'd0;
            timer_q  <= '0;
         end
      end else if (phase_end) begin
         timer_q <= '0;
         if (lcd_en_o) begin
            // High phase over
            lcd_en_o <= 1'b0;
         end else if (byte_idx == LAST_BYTE) begin
            busy_o <= 1'b0;
         end else begin
            // Next byte with a new enable pulse
            byte_idx <= byte_idx + 4'd1;
            lcd_en_o <= 1'b1;
         end
      end else begin
         timer_q <= timer_q + 1'b1;
      end
   end

endmodule

//--- rtl/team_01.sv
// ==============================
// Keypad to Wishbone terminal top
// Scanner, entry, manager, LCD
// ==============================

module team_01 #(
   parameter int SCAN_DIV        = 8,
   parameter int DEBOUNCE_PASSES = 2,
   parameter int EN_CYCLES       = 4
) (
   input  logic        clk,
   input  logic        rst_n_i,
   input  wire  [33:0] gpio_in,
   output wire  [33:0] gpio_out,
   output wire  [33:0] gpio_oeb,
   input  logic [31:0] dat_i,
   input  logic        ack_i,
   output logic [31:0] adr_o,
   output logic [31:0] dat_o,
   output logic [3:0]  sel_o,
   output logic        we_o,
   output logic        stb_o,
   output logic        cyc_o
);
   import ui_pkg::*;
   import wb_pkg::*;

   key_evt_t key_evt;
   wb_req_t  req;
   wb_rsp_t  rsp;
   wb_m2s_t  bus;
   logic     lcd_busy;

   // Rows in on 15:12, columns out on 19:16
   keypad_scan #(
      .SCAN_DIV        (SCAN_DIV),
      .DEBOUNCE_PASSES (DEBOUNCE_PASSES)
   ) u_scan (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .rows_i  (gpio_in[15:12]),
      .cols_o  (gpio_out[19:16]),
      .key_o   (key_evt)
   );

   key_entry u_entry (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .key_i      (key_evt),
      .rsp_i      (rsp),
      .lcd_busy_i (lcd_busy),
      .req_o      (req)
   );

   wishbone_manager u_wb (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (req),
      .dat_i   (dat_i),
      .ack_i   (ack_i),
      .bus_o   (bus),
      .rsp_o   (rsp)
   );

   // LCD en on 1, rs on 2, data on 11:4
   lcd_writer #(
      .EN_CYCLES (EN_CYCLES)
   ) u_lcd (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .rsp_i      (rsp),
      .lcd_data_o (gpio_out[11:4]),
      .lcd_rs_o   (gpio_out[2]),
      .lcd_en_o   (gpio_out[1]),
      .busy_o     (lcd_busy)
   );

   // Bus struct out to the pins
   assign adr_o = bus.adr;
   assign dat_o = bus.dat;
   assign sel_o = bus.sel;
   assign we_o  = bus.we;
   assign stb_o = bus.stb;
   assign cyc_o = bus.cyc;

   // LCD is write only
   assign gpio_out[3]     = 1'b0;
   assign gpio_out[0]     = 1'b0;
   assign gpio_out[15:12] = '0;
   assign gpio_out[33:20] = '0;

   // Low enables mark outputs
   assign gpio_oeb[11:0]  = '0;
   assign gpio_oeb[15:12] = 4'b1111;
   assign gpio_oeb[19:16] = '0;
   assign gpio_oeb[33:20] = '1;

endmodule

//--- rtl/ui_pkg.sv
// ==============================
// User side types and constants
// Key codes, key events, LCD bytes
// ==============================

package ui_pkg;

   // Command keys carry their keypad index
   typedef enum logic [3:0] {
      CMD_ADDR  = 4'd10,
      CMD_WRITE = 4'd11,
      CMD_READ  = 4'd12,
      CMD_CLEAR = 4'd13
   } key_cmd_e;

   // One key code read as a digit or as a command
   typedef union packed {
      logic [3:0] digit;
      key_cmd_e   cmd;
   } key_code_u;

   // is_cmd picks the view of code
   typedef struct packed {
      logic      valid;
      logic      is_cmd;
      key_code_u code;
   } key_evt_t;

   // Clear display instruction
   localparam logic [7:0] LCD_CLEAR = 8'h01;

   // Nibble to ASCII, entry 0 is '0'
   localparam logic [15:0][7:0] HEX_ASCII = "FEDCBA9876543210";

endpackage

//--- rtl/wb_pkg.sv
// ==============================
// Wishbone side types
// Request, response, bus signals
// ==============================

package wb_pkg;

   // Single transfer request from the key entry
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic        we;
      logic        valid;
   } wb_req_t;

   // Data written or read, with a done strobe
   typedef struct packed {
      logic [31:0] dat;
      logic        done;
   } wb_rsp_t;

   // Manager to subordinate signals of the classic bus
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        we;
      logic        stb;
      logic        cyc;
   } wb_m2s_t;

   // Full word transfers only
   localparam logic [3:0] SEL_ALL = 4'hF;

endpackage

//--- rtl/wishbone_manager.sv
// ==============================
// Wishbone classic manager
// Single transfers only
// ==============================

module wishbone_manager (
   input  logic            clk,
   input  logic            rst_n_i,
   input  wb_pkg::wb_req_t req_i,
   input  logic [31:0]     dat_i,
   input  logic            ack_i,
   output wb_pkg::wb_m2s_t bus_o,
   output wb_pkg::wb_rsp_t rsp_o
);
   import wb_pkg::*;

   typedef enum logic {
      S_IDLE,
      S_BUS
   } state_e;

   state_e state_q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q    <= S_IDLE;
         bus_o.sel  <= SEL_ALL;
         bus_o.we   <= 1'b0;
         bus_o.stb  <= 1'b0;
         bus_o.cyc  <= 1'b0;
         rsp_o.done <= 1'b0;
      end else begin
         rsp_o.done <= 1'b0;
         case (state_q)
            S_IDLE: begin
               // Put the request on the bus
               if (req_i.valid) begin
                  bus_o.adr <= req_i.adr;
                  bus_o.dat <= req_i.dat;
                  bus_o.sel <= SEL_ALL;
                  bus_o.we  <= req_i.we;
                  bus_o.stb <= 1'b1;
                  bus_o.cyc <= 1'b1;
                  state_q   <= S_BUS;
               end
            end
            S_BUS: begin
               // Hold cyc and stb until the subordinate acks
               if (ack_i) begin
                  bus_o.stb  <= 1'b0;
                  bus_o.cyc  <= 1'b0;
                  // Written data on a write, returned data on a read
                  rsp_o.dat  <= bus_o.we ? bus_o.dat : dat_i;
                  rsp_o.done <= 1'b1;
                  state_q    <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

endmodule

//--- sim/tb_team_01.sv
// ==============================
// Keypad terminal testbench
// Keypad and Wishbone memory models
// LCD capture, reference text, checks
// ==============================

module tb_team_01;
   timeunit 1ns;
   timeprecision 100ps;
   import ui_pkg::*;
   import wb_pkg::*;

   localparam int SCAN_TICKS = 4 * 8;
   localparam int KEY_ADDR   = 10;
   localparam int KEY_WRITE  = 11;
   localparam int KEY_READ   = 12;
   localparam int KEY_CLEAR  = 13;

   // rs in bit 8, byte below, entry 0 printed first
   typedef logic [8:0][8:0] lcd_seq_t;

   logic        clk;
   logic        rst_n_i;
   logic [33:0] gpio_in;
   logic [33:0] gpio_out;
   logic [33:0] gpio_oeb;
   logic [31:0] dat_i;
   logic        ack_i;
   logic [31:0] adr_o;
   logic [31:0] dat_o;
   logic [3:0]  sel_o;
   logic        we_o;
   logic        stb_o;
   logic        cyc_o;

   logic [3:0]  rows;
   logic        key_down;
   int          key_idx;
   logic [31:0] mem [bit [31:0]];
   integer      seed;
   int          ack_wait;
   logic        ack_armed;
   wb_m2s_t     bus_now;
   wb_m2s_t     bus_exp;
   wb_m2s_t     exp_bus_q [$];
   logic [8:0]  exp_lcd_q [$];
   logic [8:0]  got_lcd_q [$];
   logic [8:0]  lcd_got;
   logic [8:0]  lcd_exp;
   // Software copy of the entry registers
   logic [31:0] acc_ref;
   logic [31:0] addr_ref;
   int          n_xfer;
   int          n_cmd;
   int          check_errors;
   int          other_errors;

   team_01 #(
      .SCAN_DIV        (8),
      .DEBOUNCE_PASSES (2),
      .EN_CYCLES       (4)
   ) dut (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .gpio_in  (gpio_in),
      .gpio_out (gpio_out),
      .gpio_oeb (gpio_oeb),
      .dat_i    (dat_i),
      .ack_i    (ack_i),
      .adr_o    (adr_o),
      .dat_o    (dat_o),
      .sel_o    (sel_o),
      .we_o     (we_o),
      .stb_o    (stb_o),
      .cyc_o    (cyc_o)
   );

   assign gpio_in = {18'd0, rows, 12'd0};

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Unwritten words follow the whole address
   function automatic logic [31:0] fill_word(input logic [31:0] adr);
      return {adr[15:0], adr[31:16]} ^ 32'h5a3c_96e1;
   endfunction

   function automatic logic [31:0] mem_word(input logic [31:0] adr);
      if (mem.exists(adr)) return mem[adr];
      return fill_word(adr);
   endfunction

   // Clear first, then eight characters from the top nibble down
   function automatic lcd_seq_t lcd_text(input logic [31:0] word);
      lcd_seq_t   seq;
      logic [3:0] nib;
      seq[0] = {1'b0, LCD_CLEAR};
      for (int i = 0; i < 8; i++) begin
         nib = word[31 - 4 * i -: 4];
         if (nib < 4'd10) seq[i + 1] = {1'b1, 8'h30 + 8'(nib)};
         else seq[i + 1] = {1'b1, 8'h37 + 8'(nib)};
      end
      return seq;
   endfunction

   // Each nibble a decimal digit
   function automatic logic [31:0] rand_digits();
      logic [31:0] v;
      for (int i = 0; i < 8; i++) v[4 * i +: 4] = 4'($unsigned($random(seed)) % 10);
      return v;
   endfunction

   task automatic check_bus(input wb_m2s_t got, input wb_m2s_t exp);
      // Data only matters on writes
      if (got.adr !== exp.adr || got.sel !== exp.sel || got.we !== exp.we ||
          (exp.we && got.dat !== exp.dat)) begin
         check_errors++;
         $display("CHECK FAILED @%0t: bus adr=%h dat=%h sel=%h we=%b, expected %h %h %h %b",
                  $time, got.adr, got.dat, got.sel, got.we,
                  exp.adr, exp.dat, exp.sel, exp.we);
      end
   endtask

   task automatic check_lcd_byte(input logic [7:0] got_dat, input logic got_rs,
                                 input logic [7:0] exp_dat, input logic exp_rs);
      if (got_dat !== exp_dat || got_rs !== exp_rs) begin
         check_errors++;
         $display("CHECK FAILED @%0t: LCD byte %h rs=%b, expected %h rs=%b",
                  $time, got_dat, got_rs, exp_dat, exp_rs);
      end
   endtask

   // Pin directions from the pinout, unused GPIO not looked at
   task automatic check_oeb(input logic [33:0] got);
      logic [33:0] care;
      logic [33:0] exp_oeb;
      care    = '0;
      exp_oeb = '0;
      // LCD en, rs, rw and data drive out
      care[11:1]     = '1;
      // Rows come in
      care[15:12]    = '1;
      exp_oeb[15:12] = '1;
      // Columns drive out
      care[19:16]    = '1;
      if ((got & care) !== (exp_oeb & care)) begin
         check_errors++;
         $display("CHECK FAILED @%0t: gpio_oeb %h, expected %h under mask %h",
                  $time, got, exp_oeb, care);
      end
   endtask

   // Keypad matrix, the held key answers on its own column only
   always @(negedge clk) begin
      if (key_down && gpio_out[16 + key_idx % 4]) rows = 4'b0001 << (key_idx / 4);
      else rows = 4'b0000;
   end

   // Wishbone memory with a random ack delay of 0 to 5 cycles
   always @(negedge clk) begin
      if (!rst_n_i) begin
         ack_i     = 1'b0;
         ack_armed = 1'b0;
      end else if (ack_i) begin
         ack_i = 1'b0;
         if (stb_o || cyc_o) begin
            other_errors++;
            $display("ERROR @%0t: stb_o or cyc_o still high after ack_i", $time);
         end
      end else if (stb_o && cyc_o) begin
         if (!ack_armed) begin
            ack_wait  = $unsigned($random(seed)) % 6;
            ack_armed = 1'b1;
         end
         if (ack_wait == 0) begin
            ack_i     = 1'b1;
            ack_armed = 1'b0;
            n_xfer++;
            bus_now = {adr_o, dat_o, sel_o, we_o, stb_o, cyc_o};
            if (exp_bus_q.size() == 0) begin
               other_errors++;
               $display("ERROR @%0t: bus transfer without a WRITE or READ key", $time);
            end else begin
               bus_exp = exp_bus_q.pop_front();
               check_bus(bus_now, bus_exp);
            end
            if (we_o) mem[adr_o] = dat_o;
            else dat_i = mem_word(adr_o);
         end else begin
            ack_wait--;
         end
      end else if (ack_armed || stb_o || cyc_o) begin
         other_errors++;
         $display("ERROR @%0t: stb_o and cyc_o did not stay high until ack_i", $time);
         ack_armed = 1'b0;
      end
   end

   // The display latches on the falling edge of en
   always @(negedge gpio_out[1]) begin
      if (rst_n_i === 1'b1) begin
         got_lcd_q.push_back({gpio_out[2], gpio_out[11:4]});
         if (gpio_out[3] !== 1'b0) begin
            other_errors++;
            $display("ERROR @%0t: LCD rw is not held low", $time);
         end
      end
   end

   // Compare captured bytes against the expected text
   always @(negedge clk) begin
      while (got_lcd_q.size() > 0) begin
         lcd_got = got_lcd_q.pop_front();
         if (exp_lcd_q.size() == 0) begin
            other_errors++;
            $display("ERROR @%0t: LCD byte %h written when none was due", $time, lcd_got[7:0]);
         end else begin
            lcd_exp = exp_lcd_q.pop_front();
            check_lcd_byte(lcd_got[7:0], lcd_got[8], lcd_exp[7:0], lcd_exp[8]);
         end
      end
   end

   task automatic expect_lcd(input logic [31:0] word);
      lcd_seq_t seq;
      seq = lcd_text(word);
      for (int i = 0; i < 9; i++) exp_lcd_q.push_back(seq[i]);
   endtask

   task automatic expect_bus(input logic [31:0] adr, input logic [31:0] dat, input logic we);
      wb_m2s_t xfer;
      xfer.adr = adr;
      xfer.dat = dat;
      xfer.sel = 4'hF;
      xfer.we  = we;
      xfer.stb = 1'b1;
      xfer.cyc = 1'b1;
      exp_bus_q.push_back(xfer);
      n_cmd++;
   endtask

   // Hold, then release long enough for a release scan
   task automatic press(input int idx, input int hold_scans);
      @(posedge clk);
      key_idx  = idx;
      key_down = 1'b1;
      repeat (hold_scans * SCAN_TICKS) @(posedge clk);
      key_down = 1'b0;
      repeat (3 * SCAN_TICKS) @(posedge clk);
   endtask

   task automatic wait_lcd_done();
      int cycles;
      cycles = 0;
      while (exp_lcd_q.size() != 0 && cycles < 4000) begin
         @(posedge clk);
         cycles++;
      end
      if (exp_lcd_q.size() != 0) begin
         other_errors++;
         $display("ERROR @%0t: LCD did not print the expected text in time", $time);
         exp_lcd_q.delete();
      end
   endtask

   task automatic type_key(input int idx, input int hold_scans);
      if (idx < 10) begin
         acc_ref = {acc_ref[27:0], 4'(idx)};
      end else if (idx == KEY_ADDR) begin
         addr_ref = acc_ref;
         acc_ref  = '0;
      end else if (idx == KEY_WRITE) begin
         expect_bus(addr_ref, acc_ref, 1'b1);
         expect_lcd(acc_ref);
      end else if (idx == KEY_READ) begin
         expect_bus(addr_ref, '0, 1'b0);
         expect_lcd(mem_word(addr_ref));
      end else if (idx == KEY_CLEAR) begin
         acc_ref  = '0;
         addr_ref = '0;
      end
      press(idx, hold_scans);
      if (idx == KEY_WRITE || idx == KEY_READ) wait_lcd_done();
   endtask

   // Lowest n digits of val, most significant first
   task automatic enter_digits(input logic [31:0] val, input int n);
      for (int i = n - 1; i >= 0; i--) type_key(int'(val[4 * i +: 4]), 4);
   endtask

   initial begin
      seed         = 32'hc67c;
      rst_n_i      = 1'b0;
      ack_i        = 1'b0;
      dat_i        = '0;
      rows         = '0;
      key_down     = 1'b0;
      key_idx      = 0;
      acc_ref      = '0;
      addr_ref     = '0;
      n_xfer       = 0;
      n_cmd        = 0;
      check_errors = 0;
      other_errors = 0;
      repeat (5) @(negedge clk);
      rst_n_i = 1'b1;

      // Pad directions of the keypad and LCD pins
      check_oeb(gpio_oeb);

      // Address, data, write, then read back
      enter_digits(32'h1234, 4);
      type_key(KEY_ADDR, 4);
      enter_digits(32'h98765, 5);
      type_key(KEY_WRITE, 4);
      type_key(KEY_READ, 4);

      // Dead keys and long holds add nothing
      type_key(14, 4);
      type_key(15, 4);
      type_key(7, 12);
      type_key(KEY_WRITE, 12);

      // Cleared entry reads address zero
      type_key(KEY_CLEAR, 4);
      type_key(KEY_READ, 4);

      // Random words, fill pattern first, then stored data
      for (int k = 0; k < 3; k++) begin
         enter_digits(rand_digits(), 3);
         type_key(KEY_ADDR, 4);
         type_key(KEY_READ, 4);
         enter_digits(rand_digits(), 4);
         type_key(KEY_WRITE, 4);
         type_key(KEY_READ, 4);
      end

      if (n_xfer != n_cmd || exp_bus_q.size() != 0) begin
         other_errors++;
         $display("ERROR: %0d bus transfers seen for %0d WRITE and READ keys", n_xfer, n_cmd);
      end
      $display("Summary: %0d check errors, %0d other errors, %0d bus transfers",
               check_errors, other_errors, n_xfer);
      if (check_errors == 0 && other_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- tb.f
rtl/ui_pkg.sv
rtl/wb_pkg.sv
rtl/keypad_scan.sv
rtl/key_entry.sv
rtl/wishbone_manager.sv
rtl/lcd_writer.sv
rtl/team_01.sv
sim/tb_team_01.sv
